// File: src/standby_pkg.sv
// Write-only standby target types; descriptor layout is address, parity flag, reserved, count
package standby_pkg;

  localparam int unsigned ADDR_W      = 7;
  localparam int unsigned BYTE_W      = 8;
  localparam int unsigned CNT_W       = 16;
  localparam int unsigned DESC_W      = 32;
  localparam int unsigned SYNC_STAGES = 2;

  // First byte after a start is read as address, later bytes as data
  typedef union packed {
    struct packed {
      logic [ADDR_W-1:0] addr;
      logic              rnw;
    } addr_view;
    logic [BYTE_W-1:0] data;
  } bus_byte_u;

  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_evt_t;

  typedef struct packed {
    logic [ADDR_W-1:0]                  addr;
    logic                               parity_err;
    logic [DESC_W-ADDR_W-CNT_W-2:0]     rsvd;
    logic [CNT_W-1:0]                   byte_cnt;
  } rx_desc_t;

  typedef struct packed {
    logic              valid;
    logic [BYTE_W-1:0] data;
  } tti_wr_t;

  typedef struct packed {
    logic     valid;
    rx_desc_t desc;
  } desc_wr_t;

  typedef struct packed {
    logic      valid;
    bus_byte_u value;
  } addr_rpt_t;

endpackage

// File: src/bus_cond_detect.sv
// Lines are sampled at clk_i rate; events come out 3 cycles after the pin change
`timescale 1ns/1ps

module bus_cond_detect (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  scl_i,
  input  logic                  sda_i,
  output standby_pkg::bus_evt_t evt_o
);
  import standby_pkg::*;

  logic [SYNC_STAGES-1:0] scl_sync_q;
  logic [SYNC_STAGES-1:0] sda_sync_q;
  logic                   scl_q;
  logic                   sda_q;
  logic                   scl_s;
  logic                   sda_s;
  logic                   open_q;
  logic                   start_det;
  logic                   stop_det;

  assign scl_s = scl_sync_q[SYNC_STAGES-1];
  assign sda_s = sda_sync_q[SYNC_STAGES-1];

  // SDA edges while SCL stays high
  assign start_det = scl_s & scl_q & sda_q & ~sda_s;
  assign stop_det  = scl_s & scl_q & ~sda_q & sda_s;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      open_q     <= 1'b0;
    end else begin
      scl_sync_q <= {scl_sync_q[SYNC_STAGES-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SYNC_STAGES-2:0], sda_i};
      scl_q      <= scl_s;
      sda_q      <= sda_s;
      if (start_det) begin
        open_q <= 1'b1;
      end else if (stop_det) begin
        open_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_o     <= '0;
      evt_o.sda <= 1'b1;
    end else begin
      // A start inside an open transfer is a repeated start
      evt_o.start    <= start_det & ~open_q;
      evt_o.rstart   <= start_det & open_q;
      evt_o.stop     <= stop_det;
      evt_o.scl_rise <= scl_s & ~scl_q;
      evt_o.scl_fall <= ~scl_s & scl_q;
      evt_o.sda      <= sda_s;
    end
  end

endmodule

// File: src/i2c_target_rx.sv
// I2C write-only target; reads and other addresses get no ACK, queues must never back-pressure
`timescale 1ns/1ps

module i2c_target_rx (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  standby_pkg::bus_evt_t          evt_i,
  input  logic [standby_pkg::ADDR_W-1:0] sta_addr_i,
  output logic                           sda_low_o,
  output standby_pkg::tti_wr_t           data_o,
  output standby_pkg::desc_wr_t          desc_o,
  output standby_pkg::addr_rpt_t         addr_o
);
  import standby_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_AACK,
    ST_DATA,
    ST_DACK
  } state_e;

  state_e                      state_q;
  logic [$clog2(BYTE_W)-1:0]   bit_cnt_q;
  logic [CNT_W-1:0]            byte_cnt_q;
  logic [ADDR_W-1:0]           addr_q;
  bus_byte_u                   shift_q;
  bus_byte_u                   byte_w;
  logic                        wr_open_q;
  logic                        sda_low_q;
  logic                        data_vld_q;
  logic                        desc_vld_q;
  logic                        addr_vld_q;
  logic                        byte_done;

  assign byte_w.data = {shift_q.data[BYTE_W-2:0], evt_i.sda};
  assign byte_done   = evt_i.scl_rise && (bit_cnt_q == ($clog2(BYTE_W))'(BYTE_W - 1));

  always_ff @(posedge clk_i) begin
    if (evt_i.scl_rise && (state_q == ST_ADDR || state_q == ST_DATA)) begin
      shift_q <= byte_w;
    end
    if (byte_done && state_q == ST_ADDR) begin
      addr_q <= byte_w.addr_view.addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
      wr_open_q  <= 1'b0;
      sda_low_q  <= 1'b0;
      data_vld_q <= 1'b0;
      desc_vld_q <= 1'b0;
      addr_vld_q <= 1'b0;
    end else begin
      data_vld_q <= 1'b0;
      addr_vld_q <= 1'b0;
      desc_vld_q <= (evt_i.stop || evt_i.rstart) && wr_open_q && (byte_cnt_q != '0);
      if (evt_i.start || evt_i.rstart) begin
        state_q   <= ST_ADDR;
        bit_cnt_q <= '0;
        sda_low_q <= 1'b0;
        wr_open_q <= 1'b0;
      end else if (evt_i.stop) begin
        state_q   <= ST_IDLE;
        sda_low_q <= 1'b0;
        wr_open_q <= 1'b0;
      end else begin
        case (state_q)
          ST_ADDR: begin
            if (evt_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            if (byte_done) begin
              addr_vld_q <= 1'b1;
              if (byte_w.addr_view.addr == sta_addr_i && !byte_w.addr_view.rnw) begin
                state_q    <= ST_AACK;
                wr_open_q  <= 1'b1;
                byte_cnt_q <= '0;
              end else begin
                state_q <= ST_IDLE;
              end
            end
          end
          // Pull low from the fall after bit 8 to the fall after bit 9
          ST_AACK, ST_DACK: begin
            if (evt_i.scl_fall) begin
              sda_low_q <= !sda_low_q;
              if (sda_low_q) begin
                state_q <= ST_DATA;
              end
            end
          end
          ST_DATA: begin
            if (evt_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            if (byte_done) begin
              data_vld_q <= 1'b1;
              byte_cnt_q <= byte_cnt_q + 1'b1;
              state_q    <= ST_DACK;
            end
          end
          default: begin
            state_q <= ST_IDLE;
          end
        endcase
      end
    end
  end

  assign sda_low_o            = sda_low_q;
  assign data_o.valid         = data_vld_q;
  assign data_o.data          = shift_q.data;
  assign addr_o.valid         = addr_vld_q;
  assign addr_o.value         = shift_q;
  assign desc_o.valid         = desc_vld_q;
  assign desc_o.desc.addr     = addr_q;
  assign desc_o.desc.parity_err = 1'b0;
  assign desc_o.desc.rsvd     = '0;
  assign desc_o.desc.byte_cnt = byte_cnt_q;

endmodule

// File: src/i3c_target_rx.sv
// I3C SDR write-only target; no CCCs, matches only a valid dynamic address, host drives T-bits
`timescale 1ns/1ps

module i3c_target_rx (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  standby_pkg::bus_evt_t          evt_i,
  input  logic [standby_pkg::ADDR_W-1:0] dyn_addr_i,
  input  logic                           dyn_addr_valid_i,
  output logic                           sda_low_o,
  output standby_pkg::tti_wr_t           data_o,
  output standby_pkg::desc_wr_t          desc_o,
  output standby_pkg::addr_rpt_t         addr_o,
  output logic                           parity_err_o
);
  import standby_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_AACK,
    ST_DATA,
    ST_TBIT
  } state_e;

  state_e                      state_q;
  logic [$clog2(BYTE_W)-1:0]   bit_cnt_q;
  logic [CNT_W-1:0]            byte_cnt_q;
  logic [ADDR_W-1:0]           addr_q;
  bus_byte_u                   shift_q;
  bus_byte_u                   byte_w;
  logic                        wr_open_q;
  logic                        xfer_err_q;
  logic                        sda_low_q;
  logic                        data_vld_q;
  logic                        desc_vld_q;
  logic                        addr_vld_q;
  logic                        parity_q;
  logic                        byte_done;
  logic                        addr_hit;
  logic                        tbit_bad;

  assign byte_w.data = {shift_q.data[BYTE_W-2:0], evt_i.sda};
  assign byte_done   = evt_i.scl_rise && (bit_cnt_q == ($clog2(BYTE_W))'(BYTE_W - 1));
  assign addr_hit    = dyn_addr_valid_i && (byte_w.addr_view.addr == dyn_addr_i)
                       && !byte_w.addr_view.rnw;
  // Byte plus T-bit must hold an odd number of ones
  assign tbit_bad    = ~((^shift_q.data) ^ evt_i.sda);

  always_ff @(posedge clk_i) begin
    if (evt_i.scl_rise && (state_q == ST_ADDR || state_q == ST_DATA)) begin
      shift_q <= byte_w;
    end
    if (byte_done && state_q == ST_ADDR) begin
      addr_q <= byte_w.addr_view.addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
      wr_open_q  <= 1'b0;
      xfer_err_q <= 1'b0;
      sda_low_q  <= 1'b0;
      data_vld_q <= 1'b0;
      desc_vld_q <= 1'b0;
      addr_vld_q <= 1'b0;
      parity_q   <= 1'b0;
    end else begin
      data_vld_q <= 1'b0;
      addr_vld_q <= 1'b0;
      parity_q   <= 1'b0;
      desc_vld_q <= (evt_i.stop || evt_i.rstart) && wr_open_q && (byte_cnt_q != '0);
      if (evt_i.start || evt_i.rstart) begin
        state_q   <= ST_ADDR;
        bit_cnt_q <= '0;
        sda_low_q <= 1'b0;
        wr_open_q <= 1'b0;
      end else if (evt_i.stop) begin
        state_q   <= ST_IDLE;
        sda_low_q <= 1'b0;
        wr_open_q <= 1'b0;
      end else begin
        case (state_q)
          ST_ADDR: begin
            if (evt_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            if (byte_done) begin
              addr_vld_q <= 1'b1;
              if (addr_hit) begin
                state_q    <= ST_AACK;
                wr_open_q  <= 1'b1;
                xfer_err_q <= 1'b0;
                byte_cnt_q <= '0;
              end else begin
                state_q <= ST_IDLE;
              end
            end
          end
          ST_AACK: begin
            if (evt_i.scl_fall) begin
              sda_low_q <= !sda_low_q;
              if (sda_low_q) begin
                state_q <= ST_DATA;
              end
            end
          end
          ST_DATA: begin
            if (evt_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            if (byte_done) begin
              state_q <= ST_TBIT;
            end
          end
          // Byte is handed over once the T-bit is sampled
          ST_TBIT: begin
            if (evt_i.scl_rise) begin
              data_vld_q <= 1'b1;
              byte_cnt_q <= byte_cnt_q + 1'b1;
              state_q    <= ST_DATA;
              if (tbit_bad) begin
                parity_q   <= 1'b1;
                xfer_err_q <= 1'b1;
              end
            end
          end
          default: begin
            state_q <= ST_IDLE;
          end
        endcase
      end
    end
  end

  assign sda_low_o              = sda_low_q;
  assign parity_err_o           = parity_q;
  assign data_o.valid           = data_vld_q;
  assign data_o.data            = shift_q.data;
  assign addr_o.valid           = addr_vld_q;
  assign addr_o.value           = shift_q;
  assign desc_o.valid           = desc_vld_q;
  assign desc_o.desc.addr       = addr_q;
  assign desc_o.desc.parity_err = xfer_err_q;
  assign desc_o.desc.rsvd       = '0;
  assign desc_o.desc.byte_cnt   = byte_cnt_q;

endmodule

// File: src/tti_mode_select.sv
// mode_i should only change while the bus is idle; sda_o is open drain and only ever pulls low
`timescale 1ns/1ps

module tti_mode_select (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   mode_i,
  input  logic                   err_clear_i,
  input  standby_pkg::bus_evt_t  evt_i,
  input  logic                   i2c_sda_low_i,
  input  standby_pkg::tti_wr_t   i2c_data_i,
  input  standby_pkg::desc_wr_t  i2c_desc_i,
  input  standby_pkg::addr_rpt_t i2c_addr_i,
  input  logic                   i3c_sda_low_i,
  input  standby_pkg::tti_wr_t   i3c_data_i,
  input  standby_pkg::desc_wr_t  i3c_desc_i,
  input  standby_pkg::addr_rpt_t i3c_addr_i,
  input  logic                   i3c_parity_err_i,
  output logic                   sda_o,
  output standby_pkg::tti_wr_t   data_o,
  output standby_pkg::desc_wr_t  desc_o,
  output standby_pkg::addr_rpt_t addr_o,
  output logic                   bus_start_o,
  output logic                   bus_rstart_o,
  output logic                   bus_stop_o,
  output logic                   err_o
);
  import standby_pkg::*;

  // Mode 0 is I2C, mode 1 is I3C
  always_comb begin
    data_o = mode_i ? i3c_data_i : i2c_data_i;
    desc_o = mode_i ? i3c_desc_i : i2c_desc_i;
    addr_o = mode_i ? i3c_addr_i : i2c_addr_i;
  end

  assign bus_start_o  = evt_i.start;
  assign bus_rstart_o = evt_i.rstart;
  assign bus_stop_o   = evt_i.stop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sda_o <= 1'b1;
      err_o <= 1'b0;
    end else begin
      sda_o <= ~(mode_i ? i3c_sda_low_i : i2c_sda_low_i);
      // Clear wins over a same-cycle parity error
      if (err_clear_i) begin
        err_o <= 1'b0;
      end else if (mode_i && i3c_parity_err_i) begin
        err_o <= 1'b1;
      end
    end
  end

endmodule

// File: src/standby_controller.sv
// Standby target, RX path only; every TTI strobe must be accepted, there is no back-pressure
`timescale 1ns/1ps

module standby_controller (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           scl_i,
  input  logic                           sda_i,
  input  logic                           mode_i,
  input  logic                           err_clear_i,
  input  logic [standby_pkg::ADDR_W-1:0] sta_addr_i,
  input  logic [standby_pkg::ADDR_W-1:0] dyn_addr_i,
  input  logic                           dyn_addr_valid_i,
  output logic                           sda_o,
  output standby_pkg::tti_wr_t           rx_data_o,
  output standby_pkg::desc_wr_t          rx_desc_o,
  output standby_pkg::addr_rpt_t         bus_addr_o,
  output logic                           bus_start_o,
  output logic                           bus_rstart_o,
  output logic                           bus_stop_o,
  output logic                           err_o
);
  import standby_pkg::*;

  bus_evt_t  evt;
  logic      i2c_sda_low;
  tti_wr_t   i2c_data;
  desc_wr_t  i2c_desc;
  addr_rpt_t i2c_addr;
  logic      i3c_sda_low;
  tti_wr_t   i3c_data;
  desc_wr_t  i3c_desc;
  addr_rpt_t i3c_addr;
  logic      i3c_parity_err;

  bus_cond_detect u_detect (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .evt_o  (evt)
  );

  i2c_target_rx u_i2c (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .evt_i      (evt),
    .sta_addr_i (sta_addr_i),
    .sda_low_o  (i2c_sda_low),
    .data_o     (i2c_data),
    .desc_o     (i2c_desc),
    .addr_o     (i2c_addr)
  );

  i3c_target_rx u_i3c (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .evt_i            (evt),
    .dyn_addr_i       (dyn_addr_i),
    .dyn_addr_valid_i (dyn_addr_valid_i),
    .sda_low_o        (i3c_sda_low),
    .data_o           (i3c_data),
    .desc_o           (i3c_desc),
    .addr_o           (i3c_addr),
    .parity_err_o     (i3c_parity_err)
  );

  tti_mode_select u_select (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .mode_i           (mode_i),
    .err_clear_i      (err_clear_i),
    .evt_i            (evt),
    .i2c_sda_low_i    (i2c_sda_low),
    .i2c_data_i       (i2c_data),
    .i2c_desc_i       (i2c_desc),
    .i2c_addr_i       (i2c_addr),
    .i3c_sda_low_i    (i3c_sda_low),
    .i3c_data_i       (i3c_data),
    .i3c_desc_i       (i3c_desc),
    .i3c_addr_i       (i3c_addr),
    .i3c_parity_err_i (i3c_parity_err),
    .sda_o            (sda_o),
    .data_o           (rx_data_o),
    .desc_o           (rx_desc_o),
    .addr_o           (bus_addr_o),
    .bus_start_o      (bus_start_o),
    .bus_rstart_o     (bus_rstart_o),
    .bus_stop_o       (bus_stop_o),
    .err_o            (err_o)
  );

endmodule

// File: verification/bus_host_tasks.svh
// Host side of the open-drain bus; one bit spans 16 clocks, SCL is never stretched by the target
`ifndef BUS_HOST_TASKS_SVH
`define BUS_HOST_TASKS_SVH

  // Lands 1 ns after a rising edge
  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Also serves as repeated start when SCL is still high from the last bit
  task automatic start_condition();
    scl_drv = 1'b0;
    wait_clocks(4);
    sda_drv = 1'b1;
    wait_clocks(4);
    scl_drv = 1'b1;
    wait_clocks(8);
    sda_drv = 1'b0;
    wait_clocks(8);
  endtask

  task automatic stop_condition();
    scl_drv = 1'b0;
    wait_clocks(4);
    sda_drv = 1'b0;
    wait_clocks(4);
    scl_drv = 1'b1;
    wait_clocks(8);
    sda_drv = 1'b1;
    wait_clocks(8);
  endtask

  // SDA changes only in the middle of the SCL low phase
  task automatic shift_bit(input logic b);
    scl_drv = 1'b0;
    wait_clocks(4);
    sda_drv = b;
    wait_clocks(4);
    scl_drv = 1'b1;
    wait_clocks(8);
  endtask

  task automatic shift_byte(input logic [BYTE_W-1:0] b);
    for (int i = BYTE_W - 1; i >= 0; i--) begin
      shift_bit(b[i]);
    end
  endtask

  // Host releases SDA and looks for the target pulling it low
  task automatic sample_ack(output logic ack);
    scl_drv = 1'b0;
    wait_clocks(4);
    sda_drv = 1'b1;
    wait_clocks(4);
    scl_drv = 1'b1;
    wait_clocks(4);
    ack = ~sda_bus;
    wait_clocks(4);
  endtask

`endif

// File: verification/tb_standby_controller.sv
// Random write transfers in both modes against a queue model; TTI strobes are never stalled
`timescale 1ns/1ps

module tb_standby_controller;
  import standby_pkg::*;

  logic              clk;
  logic              rst_n;
  logic              scl_drv;
  logic              sda_drv;
  logic              sda_bus;
  logic              mode;
  logic              err_clear;
  logic              dyn_valid;
  logic [ADDR_W-1:0] sta_addr;
  logic [ADDR_W-1:0] dyn_addr;
  logic              sda_o;
  logic              bus_start;
  logic              bus_rstart;
  logic              bus_stop;
  logic              err;
  tti_wr_t           rx_data;
  desc_wr_t          rx_desc;
  addr_rpt_t         bus_addr;

  integer            seed;
  int                errors;
  int                tests_failed;
  logic              timed_out;
  logic              exp_err;
  int                exp_start;
  int                exp_rstart;
  int                exp_stop;
  int                cnt_start;
  int                cnt_rstart;
  int                cnt_stop;
  logic [BYTE_W-1:0] exp_data[$];
  logic [BYTE_W-1:0] exp_addr[$];
  rx_desc_t          exp_desc[$];
  logic [BYTE_W-1:0] mon_byte;
  rx_desc_t          mon_desc;

  // Open-drain line, either side can pull low
  assign sda_bus = sda_drv & sda_o;

  standby_controller DUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .scl_i            (scl_drv),
    .sda_i            (sda_bus),
    .mode_i           (mode),
    .err_clear_i      (err_clear),
    .sta_addr_i       (sta_addr),
    .dyn_addr_i       (dyn_addr),
    .dyn_addr_valid_i (dyn_valid),
    .sda_o            (sda_o),
    .rx_data_o        (rx_data),
    .rx_desc_o        (rx_desc),
    .bus_addr_o       (bus_addr),
    .bus_start_o      (bus_start),
    .bus_rstart_o     (bus_rstart),
    .bus_stop_o       (bus_stop),
    .err_o            (err)
  );

  `include "bus_host_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Strobes are sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      cnt_start  += int'(bus_start);
      cnt_rstart += int'(bus_rstart);
      cnt_stop   += int'(bus_stop);
      if (rx_data.valid) begin
        if (exp_data.size() == 0) begin
          $display("Unexpected data strobe with byte %h at %0t ns", rx_data.data, $time);
          errors++;
        end else begin
          mon_byte = exp_data.pop_front();
          if (rx_data.data != mon_byte) begin
            $display("Fail at %0t ns: data %h, expected %h", $time, rx_data.data, mon_byte);
            errors++;
          end
        end
      end
      if (rx_desc.valid) begin
        if (exp_desc.size() == 0) begin
          $display("Unexpected descriptor %h at %0t ns", rx_desc.desc, $time);
          errors++;
        end else begin
          mon_desc = exp_desc.pop_front();
          if (rx_desc.desc != mon_desc) begin
            $display("Fail at %0t ns: descriptor %h, expected %h", $time, rx_desc.desc, mon_desc);
            errors++;
          end
        end
      end
      if (bus_addr.valid) begin
        if (exp_addr.size() == 0) begin
          $display("Unexpected address report %h at %0t ns", bus_addr.value.data, $time);
          errors++;
        end else begin
          mon_byte = exp_addr.pop_front();
          if (bus_addr.value.data != mon_byte) begin
            $display("Fail at %0t ns: address %h, expected %h", $time, bus_addr.value.data,
                     mon_byte);
            errors++;
          end
        end
      end
    end
  end

  task automatic run_transfer(input logic first);
    logic [ADDR_W-1:0] target;
    logic [ADDR_W-1:0] addr;
    logic              rnw;
    logic              want_ack;
    logic              ack;
    logic              bad;
    logic              any_bad;
    logic [BYTE_W-1:0] data;
    rx_desc_t          desc;
    int                nbytes;
    target = mode ? dyn_addr : sta_addr;
    addr   = target;
    if (($random(seed) & 3) == 0) begin
      addr = 7'($random(seed));
    end
    rnw      = (($random(seed) & 7) == 0);
    want_ack = (addr == target) && !rnw && (!mode || dyn_valid);
    nbytes   = 1 + (($random(seed) & 32'h7fffffff) % 6);
    any_bad  = 1'b0;
    exp_addr.push_back({addr, rnw});
    if (first) begin
      exp_start++;
    end else begin
      exp_rstart++;
    end
    start_condition();
    shift_byte({addr, rnw});
    sample_ack(ack);
    if (ack != want_ack) begin
      $display("Fail at %0t ns: address ACK %0b, expected %0b", $time, ack, want_ack);
      errors++;
    end
    // Bytes are sent after a NACK too, an idle target ignores them
    for (int i = 0; i < nbytes; i++) begin
      data = 8'($random(seed));
      if (want_ack) begin
        exp_data.push_back(data);
      end
      shift_byte(data);
      if (mode) begin
        // T-bit makes the ones count odd unless an error is injected
        bad     = (($random(seed) & 7) == 0);
        any_bad = any_bad | (bad & want_ack);
        shift_bit(~^data ^ bad);
      end else begin
        sample_ack(ack);
        if (ack != want_ack) begin
          $display("Fail at %0t ns: data byte %h ACK %0b, expected %0b", $time, data, ack,
                   want_ack);
          errors++;
        end
      end
    end
    if (want_ack) begin
      desc.addr       = addr;
      desc.parity_err = mode & any_bad;
      desc.rsvd       = '0;
      desc.byte_cnt   = CNT_W'(nbytes);
      exp_desc.push_back(desc);
      if (mode && any_bad) begin
        exp_err = 1'b1;
      end
    end
  endtask

  task automatic run_test(input int idx);
    int errors_before;
    int waited;
    errors_before = errors;
    mode          = 1'($random(seed));
    dyn_valid     = (($random(seed) & 3) != 0);
    // Now and then both engines answer the same address
    dyn_addr      = (($random(seed) & 3) == 0) ? sta_addr : 7'h35;
    wait_clocks(4);
    run_transfer(1'b1);
    if (($random(seed) & 1) != 0) begin
      run_transfer(1'b0);
    end
    stop_condition();
    exp_stop++;
    waited = 0;
    while ((exp_data.size() != 0 || exp_desc.size() != 0 || exp_addr.size() != 0
            || cnt_stop != exp_stop) && waited < 400) begin
      wait_clocks(1);
      waited++;
    end
    if (waited >= 400) begin
      $display("Timeout: expected strobes still missing after test %0d", idx);
      timed_out = 1'b1;
    end
    if (cnt_start != exp_start || cnt_rstart != exp_rstart || cnt_stop != exp_stop) begin
      $display("Fail at %0t ns: start/rstart/stop counts %0d/%0d/%0d, expected %0d/%0d/%0d",
               $time, cnt_start, cnt_rstart, cnt_stop, exp_start, exp_rstart, exp_stop);
      errors++;
    end
    if (err !== exp_err) begin
      $display("Fail at %0t ns: err_o %0b, expected %0b", $time, err, exp_err);
      errors++;
    end
    // Occasional clear so the sticky flag is seen over several transfers
    if (($random(seed) & 3) == 0) begin
      err_clear = 1'b1;
      wait_clocks(1);
      err_clear = 1'b0;
      exp_err   = 1'b0;
    end
    if (errors != errors_before || timed_out) begin
      tests_failed++;
    end
    $display("test %0d mode %0d: %0d errors", idx, mode, errors - errors_before);
  endtask

  initial begin
    seed         = 22028;
    rst_n        = 1'b0;
    scl_drv      = 1'b1;
    sda_drv      = 1'b1;
    mode         = 1'b0;
    err_clear    = 1'b0;
    dyn_valid    = 1'b1;
    sta_addr     = 7'h2a;
    dyn_addr     = 7'h35;
    errors       = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    exp_err      = 1'b0;
    exp_start    = 0;
    exp_rstart   = 0;
    exp_stop     = 0;
    cnt_start    = 0;
    cnt_rstart   = 0;
    cnt_stop     = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait_clocks(2);
    if (sda_o !== 1'b1 || err !== 1'b0) begin
      $display("Fail at %0t ns: sda_o or err_o active after reset", $time);
      errors++;
    end
    for (int t = 0; t < 40 && !timed_out; t++) begin
      run_test(t);
    end
    $display("%0d tests failed, %0d errors in total", tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+verification
src/standby_pkg.sv
src/bus_cond_detect.sv
src/i2c_target_rx.sv
src/i3c_target_rx.sv
src/tti_mode_select.sv
src/standby_controller.sv
verification/tb_standby_controller.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_standby_controller -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
